// File: build.f
common/rvseed_isa_pkg.sv
common/rvseed_alu_pkg.sv
source/inst_decode.sv
source/reg_file.sv
source/alu.sv
lsu/data_ram.sv
lsu/lsu.sv
source/exec_core.sv
tests/exec_core_asserts.sv
tests/exec_core_tb.sv

// File: tests/exec_core_tb.sv
`default_nettype none

module exec_core_tb
    import rvseed_isa_pkg::*;
    import rvseed_alu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        logic      we;
        reg_addr_t rd;
        xlen_t     data;
        logic      taken;
        logic      ill;
        logic      is_load;
        time       due;          // negedge where retire should be seen
    } expect_t;

    logic      clk;
    logic      rst_n;
    instr_t    instr;
    logic      instr_valid;
    logic      busy;
    logic      retire;
    reg_addr_t retire_rd;
    xlen_t     retire_data;
    logic      retire_we;
    logic      branch_taken;
    logic      illegal;

    xlen_t   mregs [32];         // model register file
    xlen_t   mmem [RAM_DEPTH];   // model data memory
    expect_t exp_q [$];
    instr_t  prog [$];
    int      errors = 0;
    int      cycles = 0;
    int      limit = 0;

    exec_core dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .busy         (busy),
        .retire       (retire),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .retire_we    (retire_we),
        .branch_taken (branch_taken),
        .illegal      (illegal)
    );

    always #5 clk = ~clk;

    function automatic xlen_t sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // returns the expected retire and updates the model state
    function automatic expect_t model_step(input instr_t w);
        expect_t    e;
        logic [2:0] f3;
        logic [6:0] f7;
        xlen_t      a;
        xlen_t      b;
        xlen_t      imm_i;
        xlen_t      imm_s;
        xlen_t      addr;
        f3    = w[14:12];
        f7    = w[31:25];
        a     = mregs[w[19:15]];
        b     = mregs[w[24:20]];
        imm_i = {{52{w[31]}}, w[31:20]};
        imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
        e     = '{we: 1'b1, rd: w[11:7], data: '0, taken: 1'b0, ill: 1'b0,
                  is_load: 1'b0, due: 0};
        case (w[6:0])
            OP: begin
                case ({f7, f3})
                    {F7_BASE, F3_ADD}:  e.data = a + b;
                    {F7_SUB, F3_ADD}:   e.data = a - b;
                    {F7_BASE, F3_SLT}:  e.data = xlen_t'($signed(a) < $signed(b));
                    {F7_BASE, F3_SLTU}: e.data = xlen_t'(a < b);
                    {F7_BASE, F3_AND}:  e.data = a & b;
                    {F7_BASE, F3_OR}:   e.data = a | b;
                    {F7_BASE, F3_XOR}:  e.data = a ^ b;
                    {F7_BASE, F3_SLL}:  e.data = a << b[5:0];
                    {F7_BASE, F3_SRL}:  e.data = a >> b[5:0];
                    default:            e.ill = 1'b1;
                endcase
            end
            OP_32: begin
                case ({f7, f3})
                    {F7_BASE, F3_ADD}: e.data = sext32(a[31:0] + b[31:0]);
                    {F7_SUB, F3_ADD}:  e.data = sext32(a[31:0] - b[31:0]);
                    default:           e.ill = 1'b1;
                endcase
            end
            OP_IMM: begin
                e.data = a + imm_i;
                e.ill  = (f3 != F3_ADD);
            end
            OP_IMM_32: begin
                e.data = sext32(a[31:0] + imm_i[31:0]);
                e.ill  = (f3 != F3_ADD);
            end
            LOAD: begin
                addr      = a + imm_i;
                e.is_load = (f3 == F3_LD || f3 == F3_LW);
                e.ill     = !e.is_load;
                if (f3 == F3_LD) begin
                    e.data = mmem[addr[10:3]];
                end else begin
                    e.data = sext32(addr[2] ? mmem[addr[10:3]][63:32] : mmem[addr[10:3]][31:0]);
                end
            end
            STORE: begin
                addr = a + imm_s;
                e.we = 1'b0;
                if (f3 == F3_SD) begin
                    mmem[addr[10:3]] = b;
                end else if (f3 == F3_SW && addr[2]) begin
                    mmem[addr[10:3]][63:32] = b[31:0];
                end else if (f3 == F3_SW) begin
                    mmem[addr[10:3]][31:0] = b[31:0];
                end else begin
                    e.ill = 1'b1;
                end
            end
            BRANCH: begin
                e.we    = 1'b0;
                e.taken = (f3 == F3_BEQ) ? (a == b) : (a != b);
                e.ill   = (f3 != F3_BEQ && f3 != F3_BNE);
            end
            default: e.ill = 1'b1;
        endcase
        if (e.ill) begin
            e.we    = 1'b0;
            e.taken = 1'b0;
        end
        if (e.rd == '0) begin
            e.we = 1'b0;     // branch taken does not depend on the rd field
        end
        if (e.we) begin
            mregs[e.rd] = e.data;
        end
        return e;
    endfunction

    // one instruction of the random part of the program
    function automatic instr_t rand_instr();
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   base;
        logic [11:0] off;
        logic [6:0]  f7;
        logic        word;
        opcode_t     op;
        rd   = reg_addr_t'($urandom_range(0, 30));   // x31 stays the base
        rs1  = reg_addr_t'($urandom_range(0, 31));
        rs2  = reg_addr_t'($urandom_range(0, 31));
        base = $urandom_range(0, 1) ? 5'd31 : 5'd0;
        word = $urandom_range(0, 1);
        off  = 12'($urandom) & 12'hffc;
        f7   = ($urandom_range(0, 4) == 0) ? F7_SUB : F7_BASE;   // sub with other funct3 is illegal
        if (!word) begin
            off[2] = 1'b0;
        end
        case ($urandom_range(0, 8))
            0, 1, 2: return {f7, rs2, rs1, 3'($urandom), rd, OP};
            3:       return {f7, rs2, rs1, F3_ADD, rd, OP_32};
            4: begin
                op = $urandom_range(0, 1) ? OP_IMM : OP_IMM_32;
                return {12'($urandom), rs1, F3_ADD, rd, op};
            end
            5:       return {off, base, word ? F3_LW : F3_LD, rd, LOAD};
            6:       return {off[11:5], rs2, base, word ? F3_SW : F3_SD, off[4:0], STORE};
            7: begin
                rs2 = ($urandom_range(0, 2) == 0) ? rs1 : rs2;   // equal operands now and then
                return {off[11:5], rs2, rs1, word ? F3_BNE : F3_BEQ, off[4:0], BRANCH};
            end
            default: begin
                case ($urandom_range(0, 3))
                    0:       return {7'b0000001, rs2, rs1, F3_ADD, rd, OP};   // mul
                    1:       return {off, rs1, 3'b000, rd, LOAD};             // lb
                    2:       return {off[11:5], rs2, rs1, 3'b100, off[4:0], BRANCH};   // blt
                    default: return {off, rs1, 3'b000, rd, 7'b1100111};       // jalr
                endcase
            end
        endcase
    endfunction

    task automatic compare(input xlen_t got, input xlen_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // drives on a falling edge where the core is not stalled
    task automatic issue(input instr_t w);
        expect_t e;
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
        if ($urandom_range(0, 7) == 0) begin
            instr_valid = 1'b0;
            @(negedge clk);
        end
        e           = model_step(w);
        e.due       = $time + (e.is_load ? 20 : 10);
        instr       = w;
        instr_valid = 1'b1;
        exp_q.push_back(e);
    endtask

    always @(negedge clk) begin
        expect_t e;
        logic    exp_busy;
        if (rst_n) begin
            // busy only in the cycle between a load's acceptance and its retire
            exp_busy = exp_q.size() != 0 && exp_q[0].is_load
                       && exp_q[0].due == $time + 10;
            compare(busy, exp_busy, "busy");
            if (retire && exp_q.size() == 0) begin
                $display("Error at %0t: retire with no instruction outstanding", $time);
                errors++;
            end else if (retire) begin
                e = exp_q.pop_front();
                compare($time, e.due, "retire time");
                compare(retire_we, e.we, "retire_we");
                compare(illegal, e.ill, "illegal");
                compare(branch_taken, e.taken, "branch_taken");
                if (e.we) begin
                    compare(retire_rd, e.rd, "retire_rd");
                    compare(retire_data, e.data, "retire_data");
                end
            end else if (exp_q.size() != 0 && exp_q[0].due < $time) begin
                $display("Error at %0t: an accepted instruction never retired", $time);
                errors++;
                void'(exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: no end of run after %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        logic [11:0] off;
        void'($urandom(32'h3f02695d));
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        foreach (mregs[i]) begin
            mregs[i] = '0;
        end
        // small random register values and x31 as the load/store base
        for (int r = 1; r < 31; r++) begin
            prog.push_back({12'($urandom), 5'd0, F3_ADD, 5'(r), OP_IMM});
        end
        prog.push_back({12'd256, 5'd0, F3_ADD, 5'd31, OP_IMM});
        // each doubleword stored once before any load with a value tied to its address
        for (int i = 0; i < RAM_DEPTH; i++) begin
            off = 12'(i * 8);
            prog.push_back({off + 12'd5, reg_addr_t'($urandom_range(1, 29)), F3_ADD, 5'd30, OP_IMM});
            prog.push_back({off[11:5], 5'd30, 5'd0, F3_SD, off[4:0], STORE});
        end
        repeat (600) begin
            prog.push_back(rand_instr());
        end
        for (int r = 1; r < 32; r++) begin
            prog.push_back({F7_BASE, 5'd0, 5'(r), F3_OR, 5'(r), OP});   // readback
        end
        limit = 4 * prog.size() + 100;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (prog[i]) begin
            issue(prog[i]);
        end
        @(negedge clk);
        instr_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (5) @(negedge clk);
        errors += dut0.u_asserts.fail_count;
        $display("%0d errors over %0d instructions", errors, prog.size());
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/exec_core_asserts.sv
`default_nettype none

module exec_core_asserts
    import rvseed_isa_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      busy,
    input logic      retire,
    input reg_addr_t retire_rd,
    input logic      retire_we,
    input logic      branch_taken,
    input logic      illegal
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // a load stalls exactly one cycle
    busy_single: assert property (@(posedge clk) disable iff (!rst_n) busy |=> !busy)
        else begin
            $error("busy stayed high for more than one cycle");
            fail_count++;
        end

    we_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        retire_we |-> (retire_rd != '0))
        else begin
            $error("write-back reported to x0");
            fail_count++;
        end

    // load retires only after its wait cycle
    no_retire_busy: assert property (@(posedge clk) disable iff (!rst_n) busy |-> !retire)
        else begin
            $error("retire during a load wait cycle");
            fail_count++;
        end

    flags_with_retire: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_we || branch_taken || illegal) |-> retire)
        else begin
            $error("retire flag high without retire");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> !(retire || busy || retire_we || branch_taken || illegal))
        else begin
            $error("control output high during reset");
            fail_count++;
        end

endmodule

bind exec_core exec_core_asserts u_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .busy         (busy),
    .retire       (retire),
    .retire_rd    (retire_rd),
    .retire_we    (retire_we),
    .branch_taken (branch_taken),
    .illegal      (illegal)
);

`default_nettype wire

// File: source/exec_core.sv
`default_nettype none

module exec_core
    import rvseed_isa_pkg::*;
    import rvseed_alu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  instr_t    instr,
    input  logic      instr_valid,
    output logic      busy,          // load in its wait cycle
    output logic      retire,
    output reg_addr_t retire_rd,
    output xlen_t     retire_data,
    output logic      retire_we,
    output logic      branch_taken,
    output logic      illegal
);

    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    xlen_t       imm;
    logic        use_imm;
    alu_op_e     alu_op;
    logic        word_op;
    logic        mem_word;
    inst_class_e inst_class;
    xlen_t       rdata1;
    xlen_t       rdata2;
    xlen_t       src2;
    xlen_t       alu_res;
    logic        alu_zero;
    logic        load_done;
    xlen_t       load_data;
    logic        accept;
    logic        wb_we;
    xlen_t       wb_data;
    logic        take;

    assign accept = instr_valid && !busy;
    assign src2   = use_imm ? imm : rdata2;

    // beq takes on zero, bne on nonzero
    assign take = (instr[14:12] == F3_BNE) ? !alu_zero : alu_zero;

    // alu results write at acceptance, loads at the end of the wait cycle
    assign wb_we   = ((accept && inst_class == CLS_ALU) || load_done) && (rd != '0);
    assign wb_data = load_done ? load_data : alu_res;

    inst_decode u_dec (
        .instr      (instr),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .imm        (imm),
        .use_imm    (use_imm),
        .alu_op     (alu_op),
        .word_op    (word_op),
        .mem_word   (mem_word),
        .inst_class (inst_class)
    );

    reg_file u_rf (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .we     (wb_we),
        .rd     (rd),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    alu u_alu (
        .alu_op  (alu_op),
        .word_op (word_op),
        .src1    (rdata1),
        .src2    (src2),
        .res     (alu_res),
        .zero    (alu_zero)
    );

    lsu u_lsu (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_start  (accept && inst_class == CLS_LOAD),
        .store_start (accept && inst_class == CLS_STORE),
        .mem_word    (mem_word),
        .addr        (alu_res),      // rs1 + imm
        .store_data  (rdata2),
        .busy        (busy),
        .load_done   (load_done),
        .load_data   (load_data)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire       <= 1'b0;
            retire_we    <= 1'b0;
            branch_taken <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            retire       <= (accept && inst_class != CLS_LOAD) || load_done;
            retire_we    <= wb_we;
            branch_taken <= accept && inst_class == CLS_BRANCH && take;
            illegal      <= accept && inst_class == CLS_ILLEGAL;
        end
    end

    // payload follows the write-back path
    always_ff @(posedge clk) begin
        if (accept || load_done) begin
            retire_rd   <= rd;
            retire_data <= wb_data;
        end
    end

endmodule

`default_nettype wire

// File: lsu/lsu.sv
`default_nettype none

module lsu
    import rvseed_alu_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  load_start,    // accepted load, only in idle
    input  logic  store_start,   // accepted store, ram written at this edge
    input  logic  mem_word,      // 32-bit access
    input  xlen_t addr,          // byte address
    input  xlen_t store_data,
    output logic  busy,
    output logic  load_done,
    output xlen_t load_data
);

    lsu_state_e  state;
    lsu_state_e  state_nxt;
    byte_en_t    be;
    xlen_t       wdata;
    xlen_t       rdata;
    logic [31:0] rd_word;
    logic        ld_word;        // captured at load start
    logic        ld_hi;

    always_comb begin
        state_nxt = state;
        case (state)
            LSU_IDLE:      if (load_start) state_nxt = LSU_LOAD_WAIT;
            LSU_LOAD_WAIT: state_nxt = LSU_IDLE;   // always a single stall
            default:       state_nxt = LSU_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) state <= LSU_IDLE;
        else        state <= state_nxt;
    end

    always_ff @(posedge clk) begin
        if (load_start) begin
            ld_word <= mem_word;
            ld_hi   <= addr[2];
        end
    end

    assign busy      = (state == LSU_LOAD_WAIT);
    assign load_done = (state == LSU_LOAD_WAIT);

    // sw writes one half, data copied into both halves
    assign be    = mem_word ? (addr[2] ? 8'hf0 : 8'h0f) : 8'hff;
    assign wdata = mem_word ? {2{store_data[31:0]}} : store_data;

    data_ram u_ram (
        .clk   (clk),
        .we    (store_start),
        .be    (be),
        .addr  (addr[3 +: $bits(mem_addr_t)]),   // doubleword index
        .wdata (wdata),
        .rdata (rdata)
    );

    // lw picks a half and sign-extends
    assign rd_word   = ld_hi ? rdata[63:32] : rdata[31:0];
    assign load_data = ld_word ? {{(XLEN-32){rd_word[31]}}, rd_word} : rdata;

endmodule

`default_nettype wire

// File: lsu/data_ram.sv
`default_nettype none

module data_ram
    import rvseed_alu_pkg::*;
(
    input  logic      clk,
    input  logic      we,
    input  byte_en_t  be,
    input  mem_addr_t addr,
    input  xlen_t     wdata,
    output xlen_t     rdata    // one cycle after addr
);

    xlen_t mem [RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < XLEN/8; i++) begin
                if (be[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
        rdata <= mem[addr];   // read-before-write on the same address
    end

endmodule

`default_nettype wire

// File: source/alu.sv
`default_nettype none

module alu
    import rvseed_alu_pkg::*;
(
    input  alu_op_e alu_op,
    input  logic    word_op,   // addw, subw, addiw
    input  xlen_t   src1,
    input  xlen_t   src2,
    output xlen_t   res,
    output logic    zero       // res is all zeros
);

    xlen_t      full;
    logic [5:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = src2[5:0];
    assign lt_s  = $signed(src1) < $signed(src2);
    assign lt_u  = src1 < src2;

    always_comb begin
        case (alu_op)
            ALU_ADD:  full = src1 + src2;
            ALU_SUB:  full = src1 - src2;
            ALU_SLT:  full = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: full = {{(XLEN-1){1'b0}}, lt_u};
            ALU_AND:  full = src1 & src2;
            ALU_OR:   full = src1 | src2;
            ALU_XOR:  full = src1 ^ src2;
            ALU_SLL:  full = src1 << shamt;
            ALU_SRL:  full = src1 >> shamt;   // logical
            default:  full = '0;
        endcase
    end

    // word forms keep the low half and sign-extend it
    assign res = word_op ? {{(XLEN-32){full[31]}}, full[31:0]} : full;

    // sub then zero gives the equality test for beq/bne
    assign zero = (res == '0);

endmodule

`default_nettype wire

// File: source/reg_file.sv
`default_nettype none

module reg_file
    import rvseed_isa_pkg::*;
    import rvseed_alu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  logic      we,
    input  reg_addr_t rd,
    input  xlen_t     wdata,
    output xlen_t     rdata1,
    output xlen_t     rdata2
);

    // x0 has no storage
    xlen_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // combinational reads
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: source/inst_decode.sv
`default_nettype none

module inst_decode
    import rvseed_isa_pkg::*;
    import rvseed_alu_pkg::*;
(
    input  instr_t      instr,
    output reg_addr_t   rs1,
    output reg_addr_t   rs2,
    output reg_addr_t   rd,
    output xlen_t       imm,
    output logic        use_imm,      // second alu operand is imm
    output alu_op_e     alu_op,
    output logic        word_op,      // 32-bit form, sign-extended result
    output logic        mem_word,     // lw / sw
    output inst_class_e inst_class
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign rd  = instr[11:7];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    // sign-extended immediates
    assign imm_i = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};

    always_comb begin
        imm        = imm_i;
        use_imm    = 1'b0;
        alu_op     = ALU_ADD;
        word_op    = 1'b0;
        mem_word   = 1'b0;
        inst_class = CLS_ILLEGAL;   // anything not matched below
        case (opcode)
            OP: begin
                if (funct7 == F7_BASE) begin
                    inst_class = CLS_ALU;
                    case (funct3)
                        F3_ADD:  alu_op = ALU_ADD;
                        F3_SLL:  alu_op = ALU_SLL;
                        F3_SLT:  alu_op = ALU_SLT;
                        F3_SLTU: alu_op = ALU_SLTU;
                        F3_XOR:  alu_op = ALU_XOR;
                        F3_SRL:  alu_op = ALU_SRL;
                        F3_OR:   alu_op = ALU_OR;
                        F3_AND:  alu_op = ALU_AND;
                        default: inst_class = CLS_ILLEGAL;
                    endcase
                end else if (funct7 == F7_SUB && funct3 == F3_ADD) begin
                    inst_class = CLS_ALU;
                    alu_op     = ALU_SUB;
                end
            end
            OP_32: begin
                // only addw and subw
                if (funct3 == F3_ADD && (funct7 == F7_BASE || funct7 == F7_SUB)) begin
                    inst_class = CLS_ALU;
                    alu_op     = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    word_op    = 1'b1;
                end
            end
            OP_IMM, OP_IMM_32: begin
                if (funct3 == F3_ADD) begin   // addi, addiw
                    inst_class = CLS_ALU;
                    use_imm    = 1'b1;
                    word_op    = (opcode == OP_IMM_32);
                end
            end
            LOAD: begin
                if (funct3 == F3_LD || funct3 == F3_LW) begin
                    inst_class = CLS_LOAD;
                    use_imm    = 1'b1;                // address = rs1 + imm
                    mem_word   = (funct3 == F3_LW);
                end
            end
            STORE: begin
                if (funct3 == F3_SD || funct3 == F3_SW) begin
                    inst_class = CLS_STORE;
                    imm        = imm_s;
                    use_imm    = 1'b1;
                    mem_word   = (funct3 == F3_SW);
                end
            end
            BRANCH: begin
                if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
                    inst_class = CLS_BRANCH;
                    imm        = imm_b;      // no pc here, offset unused
                    alu_op     = ALU_SUB;    // rs1 - rs2, then zero flag
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: common/rvseed_alu_pkg.sv
`default_nettype none

package rvseed_alu_pkg;

    localparam int XLEN      = 64;
    localparam int RAM_DEPTH = 256;    // doublewords

    typedef logic [XLEN-1:0]              xlen_t;
    typedef logic [$clog2(RAM_DEPTH)-1:0] mem_addr_t;   // doubleword index
    typedef logic [XLEN/8-1:0]            byte_en_t;

    // alu operations, word forms are selected separately by word_op
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,        // also used for branch compares
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    // load/store sequencer
    typedef enum logic {
        LSU_IDLE,
        LSU_LOAD_WAIT   // ram read data arrives here
    } lsu_state_e;

endpackage

`default_nettype wire

// File: common/rvseed_isa_pkg.sv
`default_nettype none

package rvseed_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    // major opcodes, bits 6:0
    localparam opcode_t OP        = 7'b0110011;   // reg-reg
    localparam opcode_t OP_32     = 7'b0111011;   // reg-reg, word forms
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_IMM_32 = 7'b0011011;
    localparam opcode_t LOAD      = 7'b0000011;
    localparam opcode_t STORE     = 7'b0100011;
    localparam opcode_t BRANCH    = 7'b1100011;

    // funct3 for arithmetic and logic
    localparam logic [2:0] F3_ADD  = 3'b000;      // add, sub, addi, addw, subw, addiw
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 for memory accesses
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_LD   = 3'b011;
    localparam logic [2:0] F3_SW   = 3'b010;
    localparam logic [2:0] F3_SD   = 3'b011;

    // funct3 for branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;

    // funct7, only two patterns are legal here
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;   // sub, subw

    // what the execute stage does with a decoded instruction
    typedef enum logic [2:0] {
        CLS_ALU,        // result written back from the alu
        CLS_LOAD,       // two-cycle path through the lsu
        CLS_STORE,
        CLS_BRANCH,     // compare only, nothing written
        CLS_ILLEGAL
    } inst_class_e;

endpackage

`default_nettype wire
